//--- build.f
design/quad_pkg.sv
design/quad_job_ctrl.sv
design/quad_prefetch_buffer.sv
design/quad_weight_table.sv
design/quad_conv_engine.sv
design/quad_top.sv
dv/quad_checker.sv
dv/quad_tb.sv

//--- Bender.yml
package:
  name: quad

sources:
  - design/quad_pkg.sv
  - design/quad_job_ctrl.sv
  - design/quad_prefetch_buffer.sv
  - design/quad_weight_table.sv
  - design/quad_conv_engine.sv
  - design/quad_top.sv
  - target: test
    files:
      - dv/quad_checker.sv
      - dv/quad_tb.sv

//--- dv/quad_tb.sv
module quad_tb;
    import quad_pkg::*;

    localparam int          NUM_JOBS  = 8;
    localparam logic [31:0] LFSR_SEED = 32'he7ab6fd8;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    typedef struct packed {
        int relu;
        int rows;
        int len;
        int ksize;
        int kernels;
        int reuse;
        int count;
    } job_row_t;

    // relu, rows, row_len, kernel_size, kernels, reuse previous data, results
    localparam job_row_t JOB_TABLE [NUM_JOBS] = '{
        '{0, 2,  8, 3, 2, 0,  24},
        '{0, 1,  4, 1, 1, 0,   4},
        '{0, 3, 16, 4, 8, 0, 312},
        '{0, 2, 64, 2, 3, 0, 378},
        '{1, 2, 64, 2, 3, 1, 378},
        '{0, 4, 12, 4, 5, 0, 180},
        '{1, 1, 20, 1, 7, 0, 140},
        '{0, 1,  4, 4, 8, 0,   8}
    };

    logic             clk_core = 1'b0;
    logic             rst;
    logic             job_start;
    logic             job_fetch_ack;
    logic             job_fetch_complete;
    logic             job_complete_ack;
    logic [1:0]       config_valid;
    cfg_word_u        config_data;
    logic             weight_valid;
    logic [BUS_W-1:0] weight_data;
    logic             pixel_valid;
    logic [BUS_W-1:0] pixel_data;
    logic             job_accept;
    logic             job_fetch_request;
    logic             job_complete;
    logic [1:0]       config_accept;
    logic             weight_ready;
    logic             pixel_ready;
    logic             result_valid;
    result_t          result_data;

    logic [31:0] lfsr_state = LFSR_SEED;
    pixel_t      pix_mem [64][MAX_ROW_LEN];
    logic [31:0] wt_mem [MAX_KERNELS];
    int          exp_q [$];
    int          err_count = 0;
    int          check_count = 0;
    int          rcv_count = 0;

    quad_top quad_top_i (.*);

    always #4 clk_core = ~clk_core;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ LFSR_TAPS : lfsr_state >> 1;
        end
        return v;
    endfunction

    task automatic check_value(input string what, input int got, input int exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("ERR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_core);
        #1;
    endtask

    // Reference results, column fastest, then kernel, then row
    task automatic build_job(input job_row_t j);
        int sum;
        int p;
        if (j.reuse == 0) begin
            for (int r = 0; r < j.rows; r++) begin
                for (int c = 0; c < j.len; c++) begin
                    pix_mem[r][c] = pixel_t'(lfsr_bits(8));
                end
            end
            for (int k = 0; k < j.kernels; k++) begin
                wt_mem[k] = lfsr_bits(32);
            end
        end
        for (int r = 0; r < j.rows; r++) begin
            for (int k = 0; k < j.kernels; k++) begin
                for (int c = 0; c <= j.len - j.ksize; c++) begin
                    sum = 0;
                    for (int t = 0; t < j.ksize; t++) begin
                        p = pix_mem[r][c+t];
                        if (j.relu != 0 && p < 0) begin
                            p = 0;
                        end
                        sum += p * int'(weight_t'(wt_mem[k][t*8 +: 8]));
                    end
                    exp_q.push_back(sum);
                end
            end
        end
    endtask

    task automatic write_config(input int idx, input cfg_word_u word);
        config_valid[idx] = 1'b1;
        config_data       = word;
        do @(negedge clk_core); while (!config_accept[idx]);
        next_cycle();
        config_valid[idx] = 1'b0;
    endtask

    task automatic run_job(input job_row_t j);
        cfg_word_u word;
        word                  = '0;
        word.layer.relu_en    = j.relu[0];
        word.layer.num_rows   = row_cnt_t'(j.rows);
        word.layer.row_len    = row_len_t'(j.len);
        write_config(0, word);
        word                  = '0;
        word.kernel.kernel_size = 3'(j.ksize);
        word.kernel.num_kernels = 4'(j.kernels);
        write_config(1, word);
        for (int k = 0; k < j.kernels; k++) begin
            weight_valid = 1'b1;
            weight_data  = wt_mem[k];
            @(negedge clk_core);
            check_value("weight_ready", weight_ready, 1);
            next_cycle();
        end
        weight_valid = 1'b0;
        @(negedge clk_core);
        check_value("weight_ready idle", weight_ready, 0);
        next_cycle();

        job_start = 1'b1;
        do @(negedge clk_core); while (!job_accept);
        next_cycle();
        job_start = 1'b0;

        for (int r = 0; r < j.rows; r++) begin
            do @(negedge clk_core); while (!job_fetch_request);
            next_cycle();
            job_fetch_ack = 1'b1;
            next_cycle();
            job_fetch_ack = 1'b0;
            for (int w = 0; w < j.len / LANES; w++) begin
                // Roughly one gap cycle in four
                while (lfsr_bits(2) == 2'd0) begin
                    next_cycle();
                end
                pixel_valid = 1'b1;
                for (int l = 0; l < LANES; l++) begin
                    pixel_data[l*PIXEL_W +: PIXEL_W] = pix_mem[r][w*LANES+l];
                end
                next_cycle();
                pixel_valid = 1'b0;
            end
            job_fetch_complete = 1'b1;
            next_cycle();
            job_fetch_complete = 1'b0;
        end

        do @(negedge clk_core); while (!job_complete);
        check_value("result count", rcv_count, j.count);
        next_cycle();
        job_complete_ack = 1'b1;
        next_cycle();
        job_complete_ack = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Result monitor, watchdog and main sequence
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk_core) begin
        if (!rst && result_valid) begin
            rcv_count++;
            if (exp_q.size() == 0) begin
                err_count++;
                $display("Unexpected result %0d at time %0t", result_data, $time);
            end else begin
                check_value("result", int'(result_data), exp_q.pop_front());
            end
        end
    end

    initial begin
        int limit;
        limit = 500;
        foreach (JOB_TABLE[i]) begin
            limit += 40 + JOB_TABLE[i].kernels + JOB_TABLE[i].rows * (JOB_TABLE[i].len + 10
                + JOB_TABLE[i].kernels * (JOB_TABLE[i].len - JOB_TABLE[i].ksize + 1)
                * JOB_TABLE[i].ksize);
        end
        limit = limit * 3;
        repeat (limit) @(posedge clk_core);
        $display("Watchdog expired after %0d cycles, the DUT stopped responding", limit);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int err_before;
        int total;
        rst                = 1'b1;
        job_start          = 1'b0;
        job_fetch_ack      = 1'b0;
        job_fetch_complete = 1'b0;
        job_complete_ack   = 1'b0;
        config_valid       = 2'b00;
        config_data        = '0;
        weight_valid       = 1'b0;
        weight_data        = '0;
        pixel_valid        = 1'b0;
        pixel_data         = '0;
        repeat (5) @(posedge clk_core);
        #1;
        rst = 1'b0;

        for (int i = 0; i < NUM_JOBS; i++) begin
            err_before = err_count;
            rcv_count  = 0;
            build_job(JOB_TABLE[i]);
            check_value("model count", exp_q.size(), JOB_TABLE[i].count);
            run_job(JOB_TABLE[i]);
            $write("job %0d: relu %0d rows %0d len %0d ", i, JOB_TABLE[i].relu,
                   JOB_TABLE[i].rows, JOB_TABLE[i].len);
            $display("ksize %0d kernels %0d, %0d results, %0d errors", JOB_TABLE[i].ksize,
                     JOB_TABLE[i].kernels, rcv_count, err_count - err_before);
        end

        total = err_count + quad_top_i.checker_i.fail_count;
        $display("jobs %0d, checks %0d, errors %0d, assertion failures %0d",
                 NUM_JOBS, check_count, err_count, quad_top_i.checker_i.fail_count);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- dv/quad_checker.sv
module quad_checker (
    input logic       clk_core,
    input logic       rst,
    input logic [1:0] config_valid,
    input logic [1:0] config_accept,
    input logic       job_accept,
    input logic       job_fetch_request,
    input logic       job_fetch_ack,
    input logic       job_complete,
    input logic       job_complete_ack,
    input logic       result_valid,
    input logic       pixel_ready
);
    import quad_pkg::*;

    // Read by the testbench at the end of the run
    int fail_count = 0;

    cfg_accept_follows: assert property (@(posedge clk_core) disable iff (rst)
        config_accept == $past(config_valid))
    else begin
        fail_count++;
        $error("config_accept is not a registered copy of config_valid");
    end

    // Accept pulse stretched to a fixed width
    accept_width: assert property (@(posedge clk_core) disable iff (rst)
        $rose(job_accept) |-> job_accept [*ACCEPT_HOLD] ##1 !job_accept)
    else begin
        fail_count++;
        $error("job_accept high for other than ACCEPT_HOLD cycles");
    end

    fetch_req_held: assert property (@(posedge clk_core) disable iff (rst)
        job_fetch_request && !job_fetch_ack |=> job_fetch_request)
    else begin
        fail_count++;
        $error("job_fetch_request dropped before job_fetch_ack");
    end

    complete_held: assert property (@(posedge clk_core) disable iff (rst)
        job_complete && !job_complete_ack |=> job_complete)
    else begin
        fail_count++;
        $error("job_complete dropped before job_complete_ack");
    end

    no_result_after_complete: assert property (@(posedge clk_core) disable iff (rst)
        !(result_valid && job_complete))
    else begin
        fail_count++;
        $error("result_valid high while job_complete is high");
    end

    // Request and load phases never overlap
    ready_not_in_request: assert property (@(posedge clk_core) disable iff (rst)
        !(pixel_ready && job_fetch_request))
    else begin
        fail_count++;
        $error("pixel_ready high while job_fetch_request is high");
    end

endmodule

bind quad_top quad_checker checker_i (.*);

//--- design/quad_top.sv
module quad_top (
    input  logic                       clk_core,
    input  logic                       rst,
    input  logic                       job_start,
    input  logic                       job_fetch_ack,
    input  logic                       job_fetch_complete,
    input  logic                       job_complete_ack,
    input  logic [1:0]                 config_valid,
    input  quad_pkg::cfg_word_u        config_data,
    input  logic                       weight_valid,
    input  logic [quad_pkg::BUS_W-1:0] weight_data,
    input  logic                       pixel_valid,
    input  logic [quad_pkg::BUS_W-1:0] pixel_data,
    output logic                       job_accept,
    output logic                       job_fetch_request,
    output logic                       job_complete,
    output logic [1:0]                 config_accept,
    output logic                       weight_ready,
    output logic                       pixel_ready,
    output logic                       result_valid,
    output quad_pkg::result_t          result_data
);
    import quad_pkg::*;

    // Job control to datapath
    logic        kernel_cfg_wr;
    logic        row_fetch_start;
    logic        row_go;
    logic        row_done;
    row_len_t    row_len;
    logic [2:0]  kernel_size;
    logic [3:0]  num_kernels;
    logic        relu_en;

    // Engine read ports
    pix_addr_t   pix_rd_addr;
    kernel_idx_t wht_rd_kernel;
    tap_idx_t    wht_rd_tap;
    pixel_t      pixel_out;
    weight_t     weight_out;

    quad_job_ctrl job_ctrl_i (
        .clk_core           (clk_core),
        .rst                (rst),
        .job_start          (job_start),
        .job_fetch_ack      (job_fetch_ack),
        .job_fetch_complete (job_fetch_complete),
        .job_complete_ack   (job_complete_ack),
        .config_valid       (config_valid),
        .config_data        (config_data),
        .row_done           (row_done),
        .job_accept         (job_accept),
        .job_fetch_request  (job_fetch_request),
        .job_complete       (job_complete),
        .config_accept      (config_accept),
        .pixel_ready        (pixel_ready),
        .kernel_cfg_wr      (kernel_cfg_wr),
        .row_fetch_start    (row_fetch_start),
        .row_go             (row_go),
        .row_len            (row_len),
        .kernel_size        (kernel_size),
        .num_kernels        (num_kernels),
        .relu_en            (relu_en)
    );

    quad_prefetch_buffer prefetch_buffer_i (
        .clk_core        (clk_core),
        .rst             (rst),
        .row_fetch_start (row_fetch_start),
        .pixel_valid     (pixel_valid),
        .pixel_ready     (pixel_ready),
        .pixel_data      (pixel_data),
        .pix_rd_addr     (pix_rd_addr),
        .relu_en         (relu_en),
        .pixel_out       (pixel_out)
    );

    quad_weight_table weight_table_i (
        .clk_core      (clk_core),
        .rst           (rst),
        .kernel_cfg_wr (kernel_cfg_wr),
        .weight_valid  (weight_valid),
        .weight_data   (weight_data),
        .wht_rd_kernel (wht_rd_kernel),
        .wht_rd_tap    (wht_rd_tap),
        .weight_ready  (weight_ready),
        .weight_out    (weight_out)
    );

    quad_conv_engine conv_engine_i (
        .clk_core      (clk_core),
        .rst           (rst),
        .row_go        (row_go),
        .row_len       (row_len),
        .kernel_size   (kernel_size),
        .num_kernels   (num_kernels),
        .pixel_out     (pixel_out),
        .weight_out    (weight_out),
        .pix_rd_addr   (pix_rd_addr),
        .wht_rd_kernel (wht_rd_kernel),
        .wht_rd_tap    (wht_rd_tap),
        .result_valid  (result_valid),
        .result_data   (result_data),
        .row_done      (row_done)
    );

endmodule

//--- design/quad_conv_engine.sv
module quad_conv_engine (
    input  logic                  clk_core,
    input  logic                  rst,
    input  logic                  row_go,
    input  quad_pkg::row_len_t    row_len,
    input  logic [2:0]            kernel_size,
    input  logic [3:0]            num_kernels,
    input  quad_pkg::pixel_t      pixel_out,
    input  quad_pkg::weight_t     weight_out,
    output quad_pkg::pix_addr_t   pix_rd_addr,
    output quad_pkg::kernel_idx_t wht_rd_kernel,
    output quad_pkg::tap_idx_t    wht_rd_tap,
    output logic                  result_valid,
    output quad_pkg::result_t     result_data,
    output logic                  row_done
);
    import quad_pkg::*;

    logic        active;
    kernel_idx_t kern;
    pix_addr_t   col;
    tap_idx_t    tap;
    row_len_t    last_col_idx;
    logic        last_tap;
    logic        last_col;
    logic        last_kern;

    logic        s1_valid;
    logic        s1_first;
    logic        s1_last;
    logic        s1_row_end;
    logic        s2_valid;
    logic        s2_first;
    logic        s2_last;
    logic        s2_row_end;
    logic signed [PIXEL_W+WEIGHT_W-1:0] product;

    ////////////////////////////////////////////////////////////////////////////
    // Address sequencer, kernel outer, column middle, tap inner
    ////////////////////////////////////////////////////////////////////////////

    // Columns run 0 to row_len - kernel_size
    assign last_col_idx = row_len - {4'd0, kernel_size};
    assign last_tap     = ({1'b0, tap} == kernel_size - 3'd1);
    assign last_col     = ({1'b0, col} == last_col_idx);
    assign last_kern    = ({1'b0, kern} == num_kernels - 4'd1);

    always_ff @(posedge clk_core) begin
        if (rst) begin
            active <= 1'b0;
            kern   <= '0;
            col    <= '0;
            tap    <= '0;
        end else if (row_go) begin
            active <= 1'b1;
            kern   <= '0;
            col    <= '0;
            tap    <= '0;
        end else if (active) begin
            if (!last_tap) begin
                tap <= tap + 1'b1;
            end else begin
                tap <= '0;
                if (!last_col) begin
                    col <= col + 1'b1;
                end else begin
                    col <= '0;
                    if (last_kern) begin
                        active <= 1'b0;
                    end else begin
                        kern <= kern + 1'b1;
                    end
                end
            end
        end
    end

    assign pix_rd_addr   = col + {4'd0, tap};
    assign wht_rd_kernel = kern;
    assign wht_rd_tap    = tap;

    ////////////////////////////////////////////////////////////////////////////
    // Read, multiply and accumulate stages
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            result_valid <= 1'b0;
            row_done     <= 1'b0;
        end else begin
            s1_valid     <= active;
            s2_valid     <= s1_valid;
            result_valid <= s2_valid & s2_last;
            row_done     <= s2_valid & s2_last & s2_row_end;
        end
    end

    // Flags ride along with the reads
    always_ff @(posedge clk_core) begin
        s1_first   <= (tap == '0);
        s1_last    <= last_tap;
        s1_row_end <= last_col & last_kern;
        s2_first   <= s1_first;
        s2_last    <= s1_last;
        s2_row_end <= s1_row_end;
        product    <= pixel_out * weight_out;
        if (s2_valid) begin
            // First tap restarts the sum
            if (s2_first) begin
                result_data <= result_t'(product);
            end else begin
                result_data <= result_data + result_t'(product);
            end
        end
    end

endmodule

//--- design/quad_weight_table.sv
module quad_weight_table (
    input  logic                       clk_core,
    input  logic                       rst,
    input  logic                       kernel_cfg_wr,
    input  logic                       weight_valid,
    input  logic [quad_pkg::BUS_W-1:0] weight_data,
    input  quad_pkg::kernel_idx_t      wht_rd_kernel,
    input  quad_pkg::tap_idx_t         wht_rd_tap,
    output logic                       weight_ready,
    output quad_pkg::weight_t          weight_out
);
    import quad_pkg::*;

    logic [BUS_W-1:0] tap_mem [MAX_KERNELS];
    kernel_idx_t      wr_slot;
    logic             wr_en;

    // Weight stream is never held off
    assign weight_ready = weight_valid;
    assign wr_en        = weight_valid & weight_ready;

    // A new kernel setup restarts loading at slot 0
    always_ff @(posedge clk_core) begin
        if (rst || kernel_cfg_wr) begin
            wr_slot <= '0;
        end else if (wr_en) begin
            wr_slot <= wr_slot + 1'b1;
        end
    end

    always_ff @(posedge clk_core) begin
        if (wr_en) begin
            tap_mem[wr_slot] <= weight_data;
        end
    end

    // Tap 0 in the low byte
    always_ff @(posedge clk_core) begin
        weight_out <= tap_mem[wht_rd_kernel][wht_rd_tap*WEIGHT_W +: WEIGHT_W];
    end

endmodule

//--- design/quad_prefetch_buffer.sv
module quad_prefetch_buffer (
    input  logic                       clk_core,
    input  logic                       rst,
    input  logic                       row_fetch_start,
    input  logic                       pixel_valid,
    input  logic                       pixel_ready,
    input  logic [quad_pkg::BUS_W-1:0] pixel_data,
    input  quad_pkg::pix_addr_t        pix_rd_addr,
    input  logic                       relu_en,
    output quad_pkg::pixel_t           pixel_out
);
    import quad_pkg::*;

    localparam int WORD_AW = $clog2(MAX_ROW_LEN / LANES);

    pixel_t             row_mem [MAX_ROW_LEN];
    logic [WORD_AW-1:0] wr_word;
    pixel_t             rd_pix;
    logic               wr_en;

    assign wr_en = pixel_valid & pixel_ready;

    // Word counter restarts with every row fetch
    always_ff @(posedge clk_core) begin
        if (rst || row_fetch_start) begin
            wr_word <= '0;
        end else if (wr_en) begin
            wr_word <= wr_word + 1'b1;
        end
    end

    // Pixel 0 sits in the low byte
    always_ff @(posedge clk_core) begin
        if (wr_en) begin
            for (int l = 0; l < LANES; l++) begin
                row_mem[{wr_word, tap_idx_t'(l)}] <= pixel_data[l*PIXEL_W +: PIXEL_W];
            end
        end
    end

    always_ff @(posedge clk_core) begin
        rd_pix <= row_mem[pix_rd_addr];
    end

    // ReLU on the read side
    assign pixel_out = (relu_en && rd_pix < 0) ? '0 : rd_pix;

endmodule

//--- design/quad_job_ctrl.sv
module quad_job_ctrl (
    input  logic                clk_core,
    input  logic                rst,
    input  logic                job_start,
    input  logic                job_fetch_ack,
    input  logic                job_fetch_complete,
    input  logic                job_complete_ack,
    input  logic [1:0]          config_valid,
    input  quad_pkg::cfg_word_u config_data,
    input  logic                row_done,
    output logic                job_accept,
    output logic                job_fetch_request,
    output logic                job_complete,
    output logic [1:0]          config_accept,
    output logic                pixel_ready,
    output logic                kernel_cfg_wr,
    output logic                row_fetch_start,
    output logic                row_go,
    output quad_pkg::row_len_t  row_len,
    output logic [2:0]          kernel_size,
    output logic [3:0]          num_kernels,
    output logic                relu_en
);
    import quad_pkg::*;

    logic [2:0]             state;
    logic [ACCEPT_HOLD-1:0] accept_sr;
    row_cnt_t               num_rows;
    row_cnt_t               row_cnt;
    logic                   layer_wr;
    logic                   job_take;

    ////////////////////////////////////////////////////////////////////////////
    // Configuration capture
    ////////////////////////////////////////////////////////////////////////////

    // Accept follows valid by one cycle
    always_ff @(posedge clk_core) begin
        if (rst) begin
            config_accept <= '0;
        end else begin
            config_accept <= config_valid;
        end
    end

    assign layer_wr      = config_valid[0] & config_accept[0];
    assign kernel_cfg_wr = config_valid[1] & config_accept[1];

    always_ff @(posedge clk_core) begin
        if (layer_wr) begin
            relu_en  <= config_data.layer.relu_en;
            num_rows <= config_data.layer.num_rows;
            row_len  <= config_data.layer.row_len;
        end
        if (kernel_cfg_wr) begin
            kernel_size <= config_data.kernel.kernel_size;
            num_kernels <= config_data.kernel.num_kernels;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Job accept stretch
    ////////////////////////////////////////////////////////////////////////////

    assign job_take = (state == ST_IDLE) && job_start;

    always_ff @(posedge clk_core) begin
        if (rst) begin
            accept_sr <= '0;
        end else begin
            accept_sr <= {accept_sr[ACCEPT_HOLD-2:0], job_take};
        end
    end

    assign job_accept = |accept_sr;

    ////////////////////////////////////////////////////////////////////////////
    // Row sequencing FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_core) begin
        if (rst) begin
            state   <= ST_IDLE;
            row_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (job_start) begin
                        state   <= ST_FETCH_REQ;
                        row_cnt <= '0;
                    end
                end
                ST_FETCH_REQ: begin
                    if (job_fetch_ack) begin
                        state <= ST_ROW_LOAD;
                    end
                end
                ST_ROW_LOAD: begin
                    if (job_fetch_complete) begin
                        state <= ST_ROW_COMPUTE;
                    end
                end
                ST_ROW_COMPUTE: begin
                    // Next fetch only once the last result of the row is out
                    if (row_done) begin
                        if (row_cnt == num_rows - 6'd1) begin
                            state <= ST_COMPLETE;
                        end else begin
                            row_cnt <= row_cnt + 6'd1;
                            state   <= ST_FETCH_REQ;
                        end
                    end
                end
                ST_COMPLETE: begin
                    if (job_complete_ack) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign job_fetch_request = (state == ST_FETCH_REQ);
    assign pixel_ready       = (state == ST_ROW_LOAD);
    assign job_complete      = (state == ST_COMPLETE);
    assign row_fetch_start   = job_fetch_request & job_fetch_ack;
    assign row_go            = pixel_ready & job_fetch_complete;

endmodule

//--- design/quad_pkg.sv
package quad_pkg;

    // Bus and datapath widths
    localparam int BUS_W    = 32;
    localparam int LANES    = 4;
    localparam int PIXEL_W  = 8;
    localparam int WEIGHT_W = 8;
    localparam int RESULT_W = 20;

    // Layer limits
    localparam int MAX_ROW_LEN = 64;
    localparam int MAX_KERNELS = 8;
    localparam int ACCEPT_HOLD = 5;

    // Job FSM encodings
    localparam logic [2:0] ST_IDLE        = 3'd0;
    localparam logic [2:0] ST_FETCH_REQ   = 3'd1;
    localparam logic [2:0] ST_ROW_LOAD    = 3'd2;
    localparam logic [2:0] ST_ROW_COMPUTE = 3'd3;
    localparam logic [2:0] ST_COMPLETE    = 3'd4;

    typedef logic [$clog2(MAX_ROW_LEN)-1:0] pix_addr_t;
    typedef logic [$clog2(MAX_KERNELS)-1:0] kernel_idx_t;
    typedef logic [$clog2(LANES)-1:0]       tap_idx_t;
    typedef logic [6:0]                     row_len_t;
    typedef logic [5:0]                     row_cnt_t;

    typedef logic signed [PIXEL_W-1:0]  pixel_t;
    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [RESULT_W-1:0] result_t;

    // Layer shape word, config_valid[0]
    typedef struct packed {
        logic [17:0] spare;
        row_len_t    row_len;
        row_cnt_t    num_rows;
        logic        relu_en;
    } cfg_layer_t;

    // Kernel setup word, config_valid[1]
    typedef struct packed {
        logic [24:0] spare;
        logic [3:0]  num_kernels;
        logic [2:0]  kernel_size;
    } cfg_kernel_t;

    typedef union packed {
        cfg_layer_t  layer;
        cfg_kernel_t kernel;
    } cfg_word_u;

endpackage
